//--- Makefile
# Verilator build and run of the command decoder testbench
TOP := tb_dga_decode_comm
LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove the build directory and $(LOG)"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -f sources.f --top-module $(TOP) -o $(TOP)
	-./obj_dir/$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "^Test passed$$" $(LOG) || (echo "Simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf obj_dir $(LOG)

//--- hw/dga_cfg.svh
/* Field widths and command codes for the command decoder.
   Codes and modifiers not listed here decode to nothing. */
`ifndef DGA_CFG_SVH
`define DGA_CFG_SVH

// Microcode field widths
`define DGA_COMM_W 5
`define DGA_MIS_W 2

// Memory-cycle commands
`define DGA_C_FETCH 5'h10
`define DGA_C_READ 5'h12
`define DGA_C_WRITE 5'h13
`define DGA_C_FORM 5'h14

// Control commands
`define DGA_C_SIOC 5'h07
`define DGA_C_START 5'h0B
`define DGA_C_SSTOP 5'h0C
`define DGA_C_CLRTI 5'h0D
`define DGA_C_EMPID 5'h0A
`define DGA_C_LDPANC 5'h06
`define DGA_C_WCHIM 5'h11

// Modifier qualifiers
// FORM, LDPANC and WCHIM are only valid with these
`define DGA_M_FORM 2'd3
`define DGA_M_LDPANC 2'd2
`define DGA_M_WCHIM 2'd0

// Internal data bus bits loaded by SIOC
// They arrive on the idbi5 and idbi7 inputs
`define DGA_EMCL_BIT 5
`define DGA_RESET_BIT 7

`endif

//--- hw/dga_decode_comm.sv
/* Command decoder top level on a single rising-edge clk.
   Cache, I/O request and semaphore paths are not part of this block. */
`timescale 1ns/1ps

module dga_decode_comm (
  input  logic                clk,
  input  logic                rst_n,
  input  dga_pkg::comm_t      comm,
  input  logic                lcs_n,
  input  logic                erof_n,
  input  logic                idbi5,
  input  logic                idbi7,
  output dga_pkg::mem_ctl_t   mem,
  output dga_pkg::io_strobe_t strobes,
  output logic                emcl_n,
  output logic                reset
);

  // Memory-cycle section
  mem_cmd_decode mem_cmd_decode_inst (
    .clk   (clk),
    .rst_n (rst_n),
    .comm  (comm),
    .lcs_n (lcs_n),
    .mem   (mem)
  );

  // Control strobes
  io_cmd_decode io_cmd_decode_inst (
    .clk     (clk),
    .rst_n   (rst_n),
    .comm    (comm),
    .lcs_n   (lcs_n),
    .erof_n  (erof_n),
    .strobes (strobes)
  );

  // Only SIOC reaches the panel register
  panel_ctrl_reg panel_ctrl_reg_inst (
    .clk    (clk),
    .rst_n  (rst_n),
    .sioc_n (strobes.sioc_n),
    .idbi5  (idbi5),
    .idbi7  (idbi7),
    .emcl_n (emcl_n),
    .reset  (reset)
  );

endmodule

//--- hw/dga_pkg.sv
/* Struct types shared by the decoder blocks.
   Struct field order sets the packed bit order, first field is the MSB. */
`include "dga_cfg.svh"

package dga_pkg;

  // Microcode command word, 7 bits
  typedef struct packed {
    logic [`DGA_COMM_W-1:0] cscomm;
    logic [`DGA_MIS_W-1:0]  csmis;
  } comm_t;

  // Memory-cycle controls
  // fetch, mreq and write active high, form_n active low
  typedef struct packed {
    logic fetch;
    logic mreq;
    logic write;
    logic form_n;
  } mem_ctl_t;

  // Control strobes, all active low
  typedef struct packed {
    logic sstop_n;
    logic start_n;
    logic sioc_n;
    logic clrti_n;
    logic wchim_n;
    logic empid_n;
    logic ldpanc_n;
  } io_strobe_t;

endpackage

//--- hw/io_cmd_decode.sv
/* Control strobe decoder. Each strobe pulses low for one clk after its command.
   EMPID and LDPANC also need erof_n low at the command edge. */
`timescale 1ns/1ps
`include "dga_cfg.svh"

module io_cmd_decode (
  input  logic                clk,
  input  logic                rst_n,
  input  dga_pkg::comm_t      comm,
  input  logic                lcs_n,
  input  logic                erof_n,
  output dga_pkg::io_strobe_t strobes
);

  // Every strobe high
  localparam dga_pkg::io_strobe_t STROBE_IDLE = '{
    sstop_n:  1'b1,
    start_n:  1'b1,
    sioc_n:   1'b1,
    clrti_n:  1'b1,
    wchim_n:  1'b1,
    empid_n:  1'b1,
    ldpanc_n: 1'b1
  };

  logic                hit_sstop;
  logic                hit_start;
  logic                hit_sioc;
  logic                hit_clrti;
  logic                hit_wchim;
  logic                hit_empid;
  logic                hit_ldpanc;
  logic                erof;
  dga_pkg::io_strobe_t strobes_d;

  assign erof = ~erof_n;

  // Plain command matches
  always_comb begin
    hit_sstop = lcs_n && (comm.cscomm == `DGA_C_SSTOP);
    hit_start = lcs_n && (comm.cscomm == `DGA_C_START);
    hit_sioc  = lcs_n && (comm.cscomm == `DGA_C_SIOC);
    hit_clrti = lcs_n && (comm.cscomm == `DGA_C_CLRTI);
    hit_empid = lcs_n && (comm.cscomm == `DGA_C_EMPID);
  end

  // Modifier-qualified matches
  always_comb begin
    hit_wchim  = lcs_n && (comm.cscomm == `DGA_C_WCHIM) &&
                 (comm.csmis == `DGA_M_WCHIM);
    hit_ldpanc = lcs_n && (comm.cscomm == `DGA_C_LDPANC) &&
                 (comm.csmis == `DGA_M_LDPANC);
  end

  // Next-state strobes
  // The error flag is sampled together with the command
  always_comb begin
    strobes_d          = STROBE_IDLE;
    strobes_d.sstop_n  = ~hit_sstop;
    strobes_d.start_n  = ~hit_start;
    strobes_d.sioc_n   = ~hit_sioc;
    strobes_d.clrti_n  = ~hit_clrti;
    strobes_d.wchim_n  = ~hit_wchim;
    strobes_d.empid_n  = ~(hit_empid & erof);
    strobes_d.ldpanc_n = ~(hit_ldpanc & erof);
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      strobes <= STROBE_IDLE;
    end else begin
      strobes <= strobes_d;
    end
  end

endmodule

//--- hw/mem_cmd_decode.sv
/* Memory-cycle decoder. Controls are valid one clk after the command edge.
   A command is only taken while lcs_n is high. */
`timescale 1ns/1ps
`include "dga_cfg.svh"

module mem_cmd_decode (
  input  logic              clk,
  input  logic              rst_n,
  input  dga_pkg::comm_t    comm,
  input  logic              lcs_n,
  output dga_pkg::mem_ctl_t mem
);

  // All controls inactive
  localparam dga_pkg::mem_ctl_t MEM_IDLE = '{
    fetch:  1'b0,
    mreq:   1'b0,
    write:  1'b0,
    form_n: 1'b1
  };

  logic              hit_fetch;
  logic              hit_read;
  logic              hit_write;
  logic              hit_form;
  dga_pkg::mem_ctl_t mem_d;

  // Product terms, each qualified by the command enable
  always_comb begin
    hit_fetch = lcs_n && (comm.cscomm == `DGA_C_FETCH);
    hit_read  = lcs_n && (comm.cscomm == `DGA_C_READ);
    hit_write = lcs_n && (comm.cscomm == `DGA_C_WRITE);
    hit_form  = lcs_n && (comm.cscomm == `DGA_C_FORM) &&
                (comm.csmis == `DGA_M_FORM);
  end

  // Next-state controls
  always_comb begin
    mem_d        = MEM_IDLE;
    mem_d.fetch  = hit_fetch;
    mem_d.write  = hit_write;
    // Any memory cycle requests the bus
    mem_d.mreq   = hit_fetch | hit_read | hit_write | hit_form;
    mem_d.form_n = ~hit_form;
  end

  // One cycle per command
  // Back-to-back commands give back-to-back cycles
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      mem <= MEM_IDLE;
    end else begin
      mem <= mem_d;
    end
  end

endmodule

//--- hw/panel_ctrl_reg.sv
/* Panel register, loaded from the internal data bus while sioc_n is low.
   It updates two clks after the SIOC command and holds otherwise. */
`timescale 1ns/1ps

module panel_ctrl_reg (
  input  logic clk,
  input  logic rst_n,
  input  logic sioc_n,
  input  logic idbi5,
  input  logic idbi7,
  output logic emcl_n,
  output logic reset
);

  logic load;

  // Strobe is active low
  assign load = ~sioc_n;

  // Memory clear enable from bus bit 5
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      emcl_n <= 1'b0;
    end else if (load) begin
      emcl_n <= idbi5;
    end
  end

  // Panel reset from bus bit 7
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      reset <= 1'b0;
    end else if (load) begin
      reset <= idbi7;
    end
  end

endmodule

//--- sources.f
+incdir+hw
hw/dga_pkg.sv
hw/mem_cmd_decode.sv
hw/io_cmd_decode.sv
hw/panel_ctrl_reg.sv
hw/dga_decode_comm.sv
tb/dga_assertions.sv
tb/tb_dga_decode_comm.sv

//--- tb/dga_assertions.sv
/* Protocol checks bound into the decoder top level.
   All checks are off while rst_n is low. */
`timescale 1ns/1ps

module dga_assertions (
  input logic                clk,
  input logic                rst_n,
  input logic                lcs_n,
  input dga_pkg::mem_ctl_t   mem,
  input dga_pkg::io_strobe_t strobes
);

  // Any memory cycle also requests the bus
  mreq_with_cycle: assert property (
    @(posedge clk) disable iff (!rst_n)
    (mem.write || mem.fetch) |-> mem.mreq
  ) else $error("write or fetch active without mreq");

  // Commands are exclusive, so at most one strobe
  one_strobe: assert property (
    @(posedge clk) disable iff (!rst_n)
    $countones(~strobes) <= 1
  ) else $error("more than one control strobe low");

  // Disabled command field leaves both decoders idle
  lcs_idle: assert property (
    @(posedge clk) disable iff (!rst_n)
    !lcs_n |=> (mem == 4'b0001) && (strobes == 7'h7f)
  ) else $error("decoder output active after an edge with lcs_n low");

endmodule

bind dga_decode_comm dga_assertions dga_assertions_inst (
  .clk     (clk),
  .rst_n   (rst_n),
  .lcs_n   (lcs_n),
  .mem     (mem),
  .strobes (strobes)
);

//--- tb/tb_dga_decode_comm.sv
/* Testbench for the command decoder with random stimulus against a cycle model.
   Inputs change on the falling clk edge; outputs are checked on the next falling edge. */
`timescale 1ns/1ps
`include "dga_cfg.svh"

module tb_dga_decode_comm;

  localparam int CLK_PERIOD   = 8;
  localparam int RESET_CYCLES = 5;
  localparam int MAIN_CYCLES  = 2000;
  localparam int GATE_CYCLES  = 200;
  localparam int PANEL_CYCLES = 300;
  localparam int TOTAL_CYCLES = RESET_CYCLES + 1 + MAIN_CYCLES + GATE_CYCLES + PANEL_CYCLES;
  localparam int WATCHDOG_NS  = (TOTAL_CYCLES + 100) * CLK_PERIOD;

  // Test numbers
  localparam int T_RESET  = 0;
  localparam int T_MEM    = 1;
  localparam int T_STROBE = 2;
  localparam int T_GATE   = 3;
  localparam int T_PANEL  = 4;
  localparam int N_TESTS  = 5;

  localparam dga_pkg::mem_ctl_t MEM_RESET = '{fetch: 1'b0, mreq: 1'b0, write: 1'b0,
                                              form_n: 1'b1};
  localparam dga_pkg::io_strobe_t STROBE_RESET = 7'h7f;

  // Every listed command code
  localparam logic [4:0] CMD_CODES [11] = '{
    `DGA_C_FETCH, `DGA_C_READ, `DGA_C_WRITE, `DGA_C_FORM, `DGA_C_SIOC, `DGA_C_START,
    `DGA_C_SSTOP, `DGA_C_CLRTI, `DGA_C_EMPID, `DGA_C_LDPANC, `DGA_C_WCHIM
  };

  logic                clk = 1'b0;
  logic                rst_n;
  dga_pkg::comm_t      comm;
  logic                lcs_n;
  logic                erof_n;
  logic                idbi5;
  logic                idbi7;
  dga_pkg::mem_ctl_t   mem;
  dga_pkg::io_strobe_t strobes;
  logic                emcl_n;
  logic                reset;

  integer              seed;
  int                  checks [N_TESTS];
  int                  errors [N_TESTS];
  int                  panel_loads;

  // Model state the DUT should show after the coming edge
  dga_pkg::mem_ctl_t   exp_mem;
  dga_pkg::io_strobe_t exp_strobes;
  logic                exp_emcl_n;
  logic                exp_reset;

  dga_decode_comm dga_decode_comm_inst (
    .clk     (clk),
    .rst_n   (rst_n),
    .comm    (comm),
    .lcs_n   (lcs_n),
    .erof_n  (erof_n),
    .idbi5   (idbi5),
    .idbi7   (idbi7),
    .mem     (mem),
    .strobes (strobes),
    .emcl_n  (emcl_n),
    .reset   (reset)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  function automatic string test_name(input int id);
    case (id)
      T_RESET:  return "reset_values";
      T_MEM:    return "mem_decode";
      T_STROBE: return "strobe_decode";
      T_GATE:   return "lcs_gate";
      default:  return "panel_load";
    endcase
  endfunction

  function automatic int rand_below(input int n);
    logic [31:0] r;
    r = $random(seed);
    r = r & 32'h7fff_ffff;
    return int'(r) % n;
  endfunction

  function automatic logic rand_bit();
    logic [31:0] r;
    r = $random(seed);
    return r[0];
  endfunction

  function automatic logic chance(input int pct);
    return rand_below(100) < pct;
  endfunction

  // Listed code valid_pct of the time or else any 7-bit word
  function automatic dga_pkg::comm_t random_comm(input int valid_pct);
    dga_pkg::comm_t c;
    logic [31:0]    r;
    if (chance(valid_pct)) begin
      c.cscomm = CMD_CODES[rand_below(11)];
      c.csmis  = 2'(rand_below(4));
    end else begin
      r = $random(seed);
      c = r[6:0];
    end
    return c;
  endfunction

  // Memory controls for one command
  function automatic dga_pkg::mem_ctl_t model_mem(input dga_pkg::comm_t c, input logic lcs);
    dga_pkg::mem_ctl_t m;
    m = MEM_RESET;
    if (lcs) begin
      case (c.cscomm)
        `DGA_C_FETCH: begin
          m.fetch = 1'b1;
          m.mreq  = 1'b1;
        end
        `DGA_C_READ: m.mreq = 1'b1;
        `DGA_C_WRITE: begin
          m.write = 1'b1;
          m.mreq  = 1'b1;
        end
        `DGA_C_FORM: begin
          if (c.csmis == 2'd3) begin
            m.mreq   = 1'b1;
            m.form_n = 1'b0;
          end
        end
        default: ;
      endcase
    end
    return m;
  endfunction

  // Strobes for one command
  // EMPID and LDPANC also need the error flag low
  function automatic dga_pkg::io_strobe_t model_strobes(input dga_pkg::comm_t c,
                                                        input logic lcs, input logic err_n);
    dga_pkg::io_strobe_t s;
    s = STROBE_RESET;
    if (lcs) begin
      case (c.cscomm)
        `DGA_C_SSTOP:  s.sstop_n  = 1'b0;
        `DGA_C_START:  s.start_n  = 1'b0;
        `DGA_C_SIOC:   s.sioc_n   = 1'b0;
        `DGA_C_CLRTI:  s.clrti_n  = 1'b0;
        `DGA_C_WCHIM:  s.wchim_n  = (c.csmis != 2'd0);
        `DGA_C_EMPID:  s.empid_n  = err_n;
        `DGA_C_LDPANC: s.ldpanc_n = (c.csmis != 2'd2) || err_n;
        default: ;
      endcase
    end
    return s;
  endfunction

  task automatic check_mem(input int id, input dga_pkg::mem_ctl_t exp_v,
                           input dga_pkg::mem_ctl_t act_v);
    checks[id]++;
    if (act_v !== exp_v) begin
      errors[id]++;
      $display("CHECK FAILED %s: mem expected %b actual %b at %0d ns",
               test_name(id), exp_v, act_v, $time);
    end
  endtask

  task automatic check_strobes(input int id, input dga_pkg::io_strobe_t exp_v,
                               input dga_pkg::io_strobe_t act_v);
    checks[id]++;
    if (act_v !== exp_v) begin
      errors[id]++;
      $display("CHECK FAILED %s: strobes expected %b actual %b at %0d ns",
               test_name(id), exp_v, act_v, $time);
    end
  endtask

  task automatic check_panel(input int id, input logic exp_emcl_v, input logic exp_reset_v,
                             input logic act_emcl_v, input logic act_reset_v);
    checks[id]++;
    if ({act_emcl_v, act_reset_v} !== {exp_emcl_v, exp_reset_v}) begin
      errors[id]++;
      $display("CHECK FAILED %s: emcl_n,reset expected %b%b actual %b%b at %0d ns",
               test_name(id), exp_emcl_v, exp_reset_v, act_emcl_v, act_reset_v, $time);
    end
  endtask

  task automatic check_reset_state();
    check_mem(T_RESET, MEM_RESET, mem);
    check_strobes(T_RESET, STROBE_RESET, strobes);
    check_panel(T_RESET, 1'b0, 1'b0, emcl_n, reset);
  endtask

  // Drives on a falling edge and checks after the next rising edge
  task automatic apply_cycle(input dga_pkg::comm_t c, input logic lcs, input logic err_n,
                             input logic d5, input logic d7,
                             input int mem_id, input int str_id, input int pan_id);
    comm   = c;
    lcs_n  = lcs;
    erof_n = err_n;
    idbi5  = d5;
    idbi7  = d7;
    // Panel loads while the SIOC strobe from the last edge is still low
    if (!exp_strobes.sioc_n) begin
      exp_emcl_n = d5;
      exp_reset  = d7;
      panel_loads++;
    end
    exp_mem     = model_mem(c, lcs);
    exp_strobes = model_strobes(c, lcs, err_n);
    @(negedge clk);
    check_mem(mem_id, exp_mem, mem);
    check_strobes(str_id, exp_strobes, strobes);
    check_panel(pan_id, exp_emcl_n, exp_reset, emcl_n, reset);
  endtask

  task automatic report_test(input int id);
    $display("%-14s checks %5d  errors %0d", test_name(id), checks[id], errors[id]);
  endtask

  initial begin : main_seq
    dga_pkg::comm_t c;
    int             total_checks;
    int             total_errors;
    seed        = 32'h7905_e70e;
    rst_n       = 1'b0;
    comm        = '0;
    lcs_n       = 1'b0;
    erof_n      = 1'b1;
    idbi5       = 1'b0;
    idbi7       = 1'b0;
    exp_mem     = MEM_RESET;
    exp_strobes = STROBE_RESET;
    exp_emcl_n  = 1'b0;
    exp_reset   = 1'b0;
    panel_loads = 0;

    repeat (RESET_CYCLES) begin
      @(negedge clk);
      check_reset_state();
    end
    rst_n = 1'b1;
    @(negedge clk);
    check_reset_state();
    report_test(T_RESET);

    // Mem and strobe decode share one random run
    repeat (MAIN_CYCLES) begin
      c = random_comm(75);
      apply_cycle(c, chance(80), rand_bit(), rand_bit(), rand_bit(), T_MEM, T_STROBE, T_PANEL);
    end
    report_test(T_MEM);
    report_test(T_STROBE);

    repeat (GATE_CYCLES) begin
      c = random_comm(100);
      apply_cycle(c, 1'b0, rand_bit(), rand_bit(), rand_bit(), T_GATE, T_GATE, T_GATE);
    end
    report_test(T_GATE);

    // SIOC often, mixed with the other commands
    panel_loads = 0;
    repeat (PANEL_CYCLES) begin
      if (chance(40)) begin
        c.cscomm = `DGA_C_SIOC;
        c.csmis  = 2'(rand_below(4));
      end else begin
        c = random_comm(100);
      end
      apply_cycle(c, chance(80), rand_bit(), rand_bit(), rand_bit(), T_PANEL, T_PANEL, T_PANEL);
    end
    if (panel_loads == 0) begin
      errors[T_PANEL]++;
      $display("panel_load: no SIOC command ever reached the panel register");
    end
    report_test(T_PANEL);

    total_checks = 0;
    total_errors = 0;
    for (int i = 0; i < N_TESTS; i++) begin
      total_checks += checks[i];
      total_errors += errors[i];
    end
    $display("Summary: %0d tests, %0d checks, %0d errors", N_TESTS, total_checks, total_errors);
    if (total_errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

  initial begin : watchdog
    #(WATCHDOG_NS);
    $display("Watchdog: the run did not finish within %0d ns", WATCHDOG_NS);
    $display("Test failed");
    $finish;
  end

endmodule
